// File: common/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// cache geometry
`define CACHE_SETS      256
`define CACHE_WAYS      2
`define CACHE_WORDS     4

// address and data widths
`define CACHE_ADDR_W    32
`define CACHE_DATA_W    32
`define CACHE_INDEX_W   8
`define CACHE_OFFSET_W  4
`define CACHE_TAG_W     20

// victim lfsr start value
`define CACHE_LFSR_SEED 1

`endif

// File: common/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

  typedef logic [`CACHE_INDEX_W-1:0] index_t;  // set number
  typedef logic [`CACHE_TAG_W-1:0]   tag_t;
  typedef logic [`CACHE_DATA_W-1:0]  word_t;
  typedef logic [`CACHE_DATA_W/8-1:0] strb_t;  // one bit per byte
  typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

  // word 0 sits in the low bits
  typedef logic [`CACHE_WORDS*`CACHE_DATA_W-1:0] line_t;

  typedef struct packed {
    tag_t tag;
    logic valid;
  } tag_entry_t;

  // cpu address split into its fields
  typedef struct packed {
    tag_t                        tag;
    index_t                      index;
    logic [`CACHE_OFFSET_W-1:0]  offset;  // byte within line
  } addr_t;

endpackage

// File: common/cache_array_if.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

// controller to tag/data storage
interface cache_array_if ();

  cache_pkg::index_t index;  // read and write set

  // read side, one entry per way, one cycle after index
  cache_pkg::tag_t   rd_tag   [`CACHE_WAYS];
  logic              rd_valid [`CACHE_WAYS];
  logic              rd_dirty [`CACHE_WAYS];
  cache_pkg::line_t  rd_line  [`CACHE_WAYS];

  // write side, lands on next edge
  logic              wr_en;
  cache_pkg::way_t   wr_way;
  cache_pkg::tag_t   wr_tag;
  cache_pkg::line_t  wr_line;
  logic              wr_dirty;

  modport ctrl (
    output index, wr_en, wr_way, wr_tag, wr_line, wr_dirty,
    input  rd_tag, rd_valid, rd_dirty, rd_line
  );

  modport array (
    input  index, wr_en, wr_way, wr_tag, wr_line, wr_dirty,
    output rd_tag, rd_valid, rd_dirty, rd_line
  );

endinterface

// File: cache/line_ram.sv
`timescale 1ns/10ps

module line_ram #(
  parameter type entry_t = logic [31:0],
  parameter int  DEPTH   = 256
) (
  input  logic              clk,
  input  logic              reset,
  input  cache_pkg::index_t addr,
  input  logic              we,
  input  entry_t            wdata,
  output entry_t            rdata
);

  entry_t mem [DEPTH];

  // read returns the old entry when writing the same address
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++)
        mem[i] <= '0;  // valid bits start clear
      rdata <= '0;
    end else begin
      if (we)
        mem[addr] <= wdata;
      rdata <= mem[addr];
    end
  end

endmodule

// File: cache/cache_array.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_array (
  input  logic          clk,
  input  logic          reset,
  cache_array_if.array  arr
);

  for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
    logic                    we;
    cache_pkg::tag_entry_t   tag_wr;
    cache_pkg::tag_entry_t   tag_rd;
    cache_pkg::line_t        line_rd;
    logic [`CACHE_SETS-1:0]  dirty_q;
    logic                    dirty_rd;

    assign we           = arr.wr_en && (arr.wr_way == cache_pkg::way_t'(w));
    assign tag_wr.tag   = arr.wr_tag;
    assign tag_wr.valid = 1'b1;  // any write installs a line

    line_ram #(
      .entry_t (cache_pkg::tag_entry_t),
      .DEPTH   (`CACHE_SETS)
    ) u_tag_ram (
      .clk   (clk),
      .reset (reset),
      .addr  (arr.index),
      .we    (we),
      .wdata (tag_wr),
      .rdata (tag_rd)
    );

    line_ram #(
      .entry_t (cache_pkg::line_t),
      .DEPTH   (`CACHE_SETS)
    ) u_data_ram (
      .clk   (clk),
      .reset (reset),
      .addr  (arr.index),
      .we    (we),
      .wdata (arr.wr_line),
      .rdata (line_rd)
    );

    // dirty bits in flops, read with the same latency as the rams
    always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
        dirty_q  <= '0;
        dirty_rd <= 1'b0;
      end else begin
        if (we)
          dirty_q[arr.index] <= arr.wr_dirty;
        dirty_rd <= dirty_q[arr.index];
      end
    end

    assign arr.rd_tag[w]   = tag_rd.tag;
    assign arr.rd_valid[w] = tag_rd.valid;
    assign arr.rd_dirty[w] = dirty_rd;
    assign arr.rd_line[w]  = line_rd;
  end

endmodule

// File: cache/cache_ctrl.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_valid,
  input  logic                     req_write,
  input  logic [`CACHE_ADDR_W-1:0] req_addr,
  input  cache_pkg::strb_t         req_wstrb,
  input  cache_pkg::word_t         req_wdata,
  output logic                     req_ready,
  output logic                     resp_valid,
  output cache_pkg::word_t         resp_rdata,
  input  logic                     resp_ready,
  output logic                     rd_req,
  output logic [`CACHE_ADDR_W-1:0] rd_addr,
  input  logic                     rd_rdy,
  input  logic                     ret_valid,
  input  logic                     ret_last,
  input  cache_pkg::word_t         ret_data,
  output logic                     wr_req,
  output logic [`CACHE_ADDR_W-1:0] wr_addr,
  output cache_pkg::line_t         wr_data,
  input  logic                     wr_rdy,
  cache_array_if.ctrl              arr
);

  typedef enum logic [2:0] {
    st_idle, st_lookup, st_respond, st_writeback, st_refill
  } state_t;

  state_t                            state, state_nxt;
  cache_pkg::addr_t                  req_split;
  // request buffer
  logic                              write_q;
  cache_pkg::addr_t                  addr_q;
  cache_pkg::strb_t                  wstrb_q;
  cache_pkg::word_t                  wdata_q;
  logic [`CACHE_WAYS-1:0]            hit_vec;
  logic                              hit;
  cache_pkg::way_t                   hit_way;
  cache_pkg::way_t                   victim_nxt, victim_q;
  logic [7:0]                        lfsr;
  logic                              rd_sent;  // line read accepted by memory
  logic [$clog2(`CACHE_WORDS)-1:0]   beat, word_sel;
  cache_pkg::line_t                  fill_line, refill_line, base_line, merged_line;
  cache_pkg::word_t                  resp_word;

  assign req_split = req_addr;
  assign word_sel  = addr_q.offset[`CACHE_OFFSET_W-1:2];

  // lookup uses the address straight from the port, later states the buffer
  assign arr.index = (state == st_idle) ? req_split.index : addr_q.index;

  for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_hit
    assign hit_vec[w] = arr.rd_valid[w] && (arr.rd_tag[w] == addr_q.tag);
  end
  assign hit        = |hit_vec;
  assign hit_way    = cache_pkg::way_t'(hit_vec[1]);
  assign victim_nxt = cache_pkg::way_t'(lfsr[0]);

  // incoming beat dropped into its slot of the partial line
  always_comb begin
    refill_line = fill_line;
    refill_line[beat*`CACHE_DATA_W +: `CACHE_DATA_W] = ret_data;
  end

  assign base_line = (state == st_refill) ? refill_line : arr.rd_line[hit_way];

  // store bytes over the addressed word; loads pass through
  always_comb begin
    merged_line = base_line;
    for (int b = 0; b < `CACHE_DATA_W/8; b++) begin
      if (write_q && wstrb_q[b])
        merged_line[word_sel*`CACHE_DATA_W + b*8 +: 8] = wdata_q[b*8 +: 8];
    end
  end
  assign resp_word = merged_line[word_sel*`CACHE_DATA_W +: `CACHE_DATA_W];

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:
        if (req_valid) state_nxt = st_lookup;
      st_lookup:
        if (hit)
          state_nxt = st_respond;
        else if (arr.rd_valid[victim_nxt] && arr.rd_dirty[victim_nxt])
          state_nxt = st_writeback;  // dirty victim goes out first
        else
          state_nxt = st_refill;
      st_writeback:
        if (wr_rdy) state_nxt = st_refill;
      st_refill:
        if (ret_valid && ret_last) state_nxt = st_respond;
      st_respond:
        if (resp_ready) state_nxt = st_idle;
      default:
        state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= st_idle;
      lfsr     <= 8'(`CACHE_LFSR_SEED);
      victim_q <= '0;
      rd_sent  <= 1'b0;
      beat     <= '0;
    end else begin
      state <= state_nxt;
      lfsr  <= {lfsr[6:0], lfsr[7] ^ lfsr[5]};  // x^8+x^6+1
      if (state == st_lookup)
        victim_q <= victim_nxt;
      if (state != st_refill)
        rd_sent <= 1'b0;
      else if (rd_req && rd_rdy)
        rd_sent <= 1'b1;
      if (state != st_refill)
        beat <= '0;
      else if (ret_valid)
        beat <= beat + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      write_q <= req_write;
      addr_q  <= req_split;
      wstrb_q <= req_wstrb;
      wdata_q <= req_wdata;
    end
    if (state == st_refill && ret_valid)
      fill_line <= refill_line;
    if ((state == st_lookup && hit) || (state == st_refill && ret_valid && ret_last))
      resp_rdata <= resp_word;  // held through respond
  end

  // hit store or last refill beat updates the way
  assign arr.wr_en    = (state == st_lookup && hit && write_q) ||
                        (state == st_refill && ret_valid && ret_last);
  assign arr.wr_way   = (state == st_refill) ? victim_q : hit_way;
  assign arr.wr_tag   = addr_q.tag;
  assign arr.wr_line  = merged_line;
  assign arr.wr_dirty = write_q;

  assign req_ready  = (state == st_idle);
  assign resp_valid = (state == st_respond);

  assign rd_req  = (state == st_refill) && !rd_sent;
  assign rd_addr = {addr_q.tag, addr_q.index, {`CACHE_OFFSET_W{1'b0}}};

  // array output stays put while waiting, no writes happen here
  assign wr_req  = (state == st_writeback);
  assign wr_addr = {arr.rd_tag[victim_q], addr_q.index, {`CACHE_OFFSET_W{1'b0}}};
  assign wr_data = arr.rd_line[victim_q];

endmodule

// File: hdl/cache_top.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_top (
  input  logic                     clk,
  input  logic                     reset,

  // cpu request / response
  input  logic                     req_valid,
  input  logic                     req_write,
  input  logic [`CACHE_ADDR_W-1:0] req_addr,
  input  cache_pkg::strb_t         req_wstrb,
  input  cache_pkg::word_t         req_wdata,
  output logic                     req_ready,
  output logic                     resp_valid,
  output cache_pkg::word_t         resp_rdata,
  input  logic                     resp_ready,

  // memory line read
  output logic                     rd_req,
  output logic [`CACHE_ADDR_W-1:0] rd_addr,
  input  logic                     rd_rdy,
  input  logic                     ret_valid,
  input  logic                     ret_last,
  input  cache_pkg::word_t         ret_data,

  // memory line write
  output logic                     wr_req,
  output logic [`CACHE_ADDR_W-1:0] wr_addr,
  output cache_pkg::line_t         wr_data,
  input  logic                     wr_rdy
);

  cache_array_if arr_if ();

  cache_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_write  (req_write),
    .req_addr   (req_addr),
    .req_wstrb  (req_wstrb),
    .req_wdata  (req_wdata),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_ready (resp_ready),
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .rd_rdy     (rd_rdy),
    .ret_valid  (ret_valid),
    .ret_last   (ret_last),
    .ret_data   (ret_data),
    .wr_req     (wr_req),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_rdy     (wr_rdy),
    .arr        (arr_if.ctrl)
  );

  cache_array u_array (
    .clk   (clk),
    .reset (reset),
    .arr   (arr_if.array)
  );

endmodule

// File: sim/cache_asserts.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_asserts (
  input logic                     clk,
  input logic                     reset,
  input logic                     req_valid,
  input logic                     req_ready,
  input logic                     resp_valid,
  input cache_pkg::word_t         resp_rdata,
  input logic                     resp_ready,
  input logic                     rd_req,
  input logic [`CACHE_ADDR_W-1:0] rd_addr,
  input logic                     rd_rdy,
  input logic                     wr_req,
  input logic [`CACHE_ADDR_W-1:0] wr_addr,
  input cache_pkg::line_t         wr_data,
  input logic                     wr_rdy
);

  int failures = 0;  // read by the testbench monitor

  a_reset_idle: assert property (@(posedge clk)
    $fell(reset) |-> req_ready && !resp_valid && !rd_req && !wr_req)
    else begin
      $error("outputs not idle after reset release");
      failures++;
    end

  // one lookup cycle, then the hit response
  a_lookup_gap: assert property (@(posedge clk) disable iff (reset)
    $past(req_valid && req_ready) |-> !resp_valid)
    else begin
      $error("response during the lookup cycle");
      failures++;
    end

  a_hit_latency: assert property (@(posedge clk) disable iff (reset)
    $past(req_valid && req_ready, 2) && !rd_req && !wr_req |-> resp_valid)
    else begin
      $error("hit response not two cycles after acceptance");
      failures++;
    end

  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata) && !req_ready)
    else begin
      $error("response changed or request opened under back-pressure");
      failures++;
    end

  a_rd_hold: assert property (@(posedge clk) disable iff (reset)
    rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
    else begin
      $error("line read request dropped or moved before rd_rdy");
      failures++;
    end

  a_wr_hold: assert property (@(posedge clk) disable iff (reset)
    wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data))
    else begin
      $error("line write request dropped or moved before wr_rdy");
      failures++;
    end

endmodule

bind cache_top cache_asserts u_asserts (.*);

// File: sim/cache_tb.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_tb;

  localparam int CYCLE_LIMIT = 12000;  // ~300 requests at up to 35 cycles

  logic                     clk = 1'b0;
  logic                     reset;
  logic                     req_valid, req_write, req_ready;
  logic [`CACHE_ADDR_W-1:0] req_addr, rd_addr, wr_addr;
  cache_pkg::strb_t         req_wstrb;
  cache_pkg::word_t         req_wdata, resp_rdata, ret_data;
  logic                     resp_valid, resp_ready;
  logic                     rd_req, rd_rdy, ret_valid, ret_last;
  logic                     wr_req, wr_rdy;
  cache_pkg::line_t         wr_data;
  int                       cycles = 0;

  cache_pkg::word_t mem_words [logic [31:0]];  // words written back by the cache
  cache_pkg::word_t shadow    [logic [31:0]];  // words stored by the cpu side

  always #20 clk = ~clk;

  cache_top uut (.*);

  // untouched memory content, a hash of the full address
  function automatic cache_pkg::word_t fill_word(logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic cache_pkg::word_t memory_word(logic [31:0] addr);
    return mem_words.exists(addr) ? mem_words[addr] : fill_word(addr);
  endfunction

  function automatic cache_pkg::word_t expected_word(logic [31:0] addr);
    return shadow.exists(addr) ? shadow[addr] : fill_word(addr);
  endfunction

  function automatic cache_pkg::word_t merge_bytes(cache_pkg::word_t old_word,
                                                   cache_pkg::word_t data,
                                                   cache_pkg::strb_t strb);
    cache_pkg::word_t w;
    w = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b])
        w[b*8 +: 8] = data[b*8 +: 8];
    end
    return w;
  endfunction

  function automatic cache_pkg::strb_t random_strb();
    return cache_pkg::strb_t'($urandom_range(15, 1));
  endfunction

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic report_mismatch(string name, cache_pkg::word_t got, cache_pkg::word_t exp);
    $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    abort_run();
  endtask

  // one cpu request, waits for its response and checks the word
  task automatic cpu_access(logic write, logic [31:0] addr, cache_pkg::strb_t strb,
                            cache_pkg::word_t data);
    cache_pkg::word_t exp;
    exp = expected_word(addr);
    if (write)
      exp = merge_bytes(exp, data, strb);
    req_valid <= 1'b1;
    req_write <= write;
    req_addr  <= addr;
    req_wstrb <= strb;
    req_wdata <= data;
    @(negedge clk);
    while (!req_ready)
      @(negedge clk);
    @(posedge clk);  // accepting edge
    req_valid <= 1'b0;
    @(negedge clk);
    while (!(resp_valid && resp_ready))
      @(negedge clk);
    assert (resp_rdata == exp) else report_mismatch("resp_rdata", resp_rdata, exp);
    @(posedge clk);  // response taken
    if (write)
      shadow[addr] = exp;
  endtask

  task automatic serve_write();
    logic [31:0]      base;
    cache_pkg::word_t got, exp;
    base = wr_addr;
    assert (base[3:0] == 4'h0) else begin
      $display("write-back address %h is not line aligned", base);
      abort_run();
    end
    for (int i = 0; i < `CACHE_WORDS; i++) begin
      got = wr_data[i*32 +: 32];
      exp = expected_word(base + 32'(4 * i));
      assert (got == exp) else report_mismatch("wr_data", got, exp);
      mem_words[base + 32'(4 * i)] = got;
    end
    @(posedge clk);
    repeat ($urandom_range(3, 0)) @(posedge clk);
    wr_rdy <= 1'b1;
    @(posedge clk);  // handshake edge
    wr_rdy <= 1'b0;
  endtask

  task automatic serve_read();
    logic [31:0] base;
    base = rd_addr;
    assert (base[3:0] == 4'h0) else begin
      $display("line read address %h is not line aligned", base);
      abort_run();
    end
    @(posedge clk);
    repeat ($urandom_range(3, 0)) @(posedge clk);
    rd_rdy <= 1'b1;
    @(posedge clk);
    rd_rdy <= 1'b0;
    for (int i = 0; i < `CACHE_WORDS; i++) begin
      ret_valid <= 1'b1;
      ret_last  <= (i == `CACHE_WORDS - 1);
      ret_data  <= memory_word(base + 32'(4 * i));
      @(posedge clk);
    end
    ret_valid <= 1'b0;
    ret_last  <= 1'b0;
  endtask

  initial begin : memory_model
    rd_rdy    = 1'b0;
    ret_valid = 1'b0;
    ret_last  = 1'b0;
    ret_data  = '0;
    wr_rdy    = 1'b0;
    forever begin
      @(negedge clk);  // requests looked at mid-cycle
      if (wr_req)
        serve_write();
      else if (rd_req)
        serve_read();
    end
  end

  initial begin : response_backpressure
    resp_ready = 1'b0;
    forever begin
      @(posedge clk);
      resp_ready <= ($urandom_range(3, 0) != 0);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles before the tests finished", cycles);
      abort_run();
    end else if (uut.u_asserts.failures != 0) begin
      $display("a bound handshake assertion failed");
      abort_run();
    end
  end

  task automatic cold_read_then_hit();
    cpu_access(1'b0, 32'h0001_2340, 4'h0, '0);  // refill
    cpu_access(1'b0, 32'h0001_2340, 4'h0, '0);  // same word, hit
    cpu_access(1'b0, 32'h0001_234C, 4'h0, '0);
  endtask

  task automatic store_merge();
    cpu_access(1'b1, 32'h0002_5678, random_strb(), $urandom());  // miss store
    cpu_access(1'b0, 32'h0002_5678, 4'h0, '0);
    cpu_access(1'b1, 32'h0002_5678, random_strb(), $urandom());  // hit store
    cpu_access(1'b0, 32'h0002_5678, 4'h0, '0);
  endtask

  // three tags on one set, two ways
  task automatic same_set_eviction();
    logic [19:0] tags [3] = '{20'h00100, 20'h00200, 20'h00300};
    for (int round = 0; round < 2; round++) begin
      for (int t = 0; t < 3; t++)
        cpu_access(1'b1, {tags[t], 8'hA5, 2'(round + t), 2'b00}, random_strb(), $urandom());
    end
    for (int t = 0; t < 3; t++) begin
      for (int w = 0; w < `CACHE_WORDS; w++)
        cpu_access(1'b0, {tags[t], 8'hA5, 2'(w), 2'b00}, 4'h0, '0);
    end
  endtask

  // 16 lines over sets 0x10 to 0x13
  task automatic random_traffic(int count);
    logic [19:0] tags [4] = '{20'h00040, 20'h00041, 20'h00080, 20'h000C3};
    logic [31:0] addr;
    logic        write;
    int          t;
    for (int n = 0; n < count; n++) begin
      t     = $urandom_range(3, 0);
      addr  = {tags[t], 8'(8'h10 + $urandom_range(3, 0)), 2'($urandom_range(3, 0)), 2'b00};
      write = 1'($urandom_range(1, 0));
      cpu_access(write, addr, cache_pkg::strb_t'($urandom_range(15, 0)), $urandom());
    end
  endtask

  initial begin : stimulus
    void'($urandom(11));
    reset     = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wstrb = '0;
    req_wdata = '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    repeat (3) @(posedge clk);
    cold_read_then_hit();
    store_merge();
    same_set_eviction();
    random_traffic(250);
    repeat (2) @(posedge clk);
    if (uut.u_asserts.failures != 0) begin
      $display("a bound handshake assertion failed");
      abort_run();
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// File: tb.f
+incdir+common
common/cache_pkg.sv
common/cache_array_if.sv
cache/line_ram.sv
cache/cache_array.sv
cache/cache_ctrl.sv
hdl/cache_top.sv
sim/cache_asserts.sv
sim/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module cache_tb -o cache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cache_sim +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "PASS: all tests" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
